/* src/cc_macros.svh */
// --------------------
// Width and sizing macros for the
// accelerator offload cluster
// --------------------

`ifndef CC_MACROS_SVH
`define CC_MACROS_SVH

// Operand and result width
`define CC_DATA_W 32

// Request tag width
`define CC_ID_W 5

// Unit select width
`define CC_SEL_W 2

// Number of accelerator units, sel values at or above are invalid
`define CC_NUM_UNITS 3

// Iterations of the shift-and-add multiplier
`define CC_MUL_CYCLES `CC_DATA_W

`endif

/* src/acc_unit_pkg.sv */
// --------------------
// Accelerator opcode and unit state
// enums, multiply counter type
// --------------------

`default_nettype none

`include "cc_macros.svh"

package acc_unit_pkg;

  // Opcodes, 3'd7 is not legal
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    MUL = 3'd6
  } acc_op_e;

  // Unit FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } unit_state_e;

  // Iteration counter of the multiplier
  typedef logic [$clog2(`CC_MUL_CYCLES)-1:0] mul_cnt_t;

endpackage

`default_nettype wire

/* src/offload_pkg.sv */
// --------------------
// Offload request and response structs
// at the cluster boundary
// --------------------

`default_nettype none

`include "cc_macros.svh"

package offload_pkg;

  // --------------------
  // Request
  // --------------------
  typedef struct packed {
    logic [`CC_ID_W-1:0]   id;
    logic [`CC_SEL_W-1:0]  sel;
    acc_unit_pkg::acc_op_e op;
    logic [`CC_DATA_W-1:0] arga;
    logic [`CC_DATA_W-1:0] argb;
  } offload_req_t;

  // --------------------
  // Response
  // --------------------
  // error is set only for an unmatched select
  typedef struct packed {
    logic [`CC_ID_W-1:0]   id;
    logic [`CC_DATA_W-1:0] data;
    logic                  error;
  } offload_rsp_t;

endpackage

`default_nettype wire

/* src/offload_dispatch.sv */
// --------------------
// Offload dispatcher: request cut register
// and select decode to units or error path
// --------------------

`default_nettype none

`include "cc_macros.svh"

module offload_dispatch (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  offload_pkg::offload_req_t  req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output offload_pkg::offload_req_t  unit_req_o,
  output logic [`CC_NUM_UNITS-1:0]   unit_valid_o,
  input  logic [`CC_NUM_UNITS-1:0]   unit_ready_i,
  output offload_pkg::offload_rsp_t  err_rsp_o,
  output logic                       err_valid_o,
  input  logic                       err_ready_i
);

  offload_pkg::offload_req_t req_q;
  logic                      valid_q;
  logic                      sel_ok;
  logic                      drain;
  logic                      accept;

  // --------------------
  // Decode
  // --------------------
  assign sel_ok = (req_q.sel < `CC_NUM_UNITS);

  // Held item leaves on the downstream handshake of its target
  assign drain = valid_q & (sel_ok ? unit_ready_i[req_q.sel] : err_ready_i);

  // Empty, or emptying on this edge
  assign req_ready_o = ~valid_q | drain;
  assign accept      = req_valid_i & req_ready_o;

  // All units see the same payload
  assign unit_req_o = req_q;

  // One-hot valid toward the selected unit
  assign unit_valid_o = (valid_q & sel_ok) ?
                        (`CC_NUM_UNITS'(1) << req_q.sel) : '0;

  // Unmatched select becomes an error response
  assign err_valid_o = valid_q & ~sel_ok;
  assign err_rsp_o   = '{
    id:    req_q.id,
    data:  '0,
    error: 1'b1
  };

  // --------------------
  // Request register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (drain) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

endmodule

`default_nettype wire

/* src/acc_unit.sv */
// --------------------
// Integer accelerator unit with single
// cycle logic ops and iterative multiply
// --------------------

`default_nettype none

`include "cc_macros.svh"

module acc_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  offload_pkg::offload_req_t  req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output offload_pkg::offload_rsp_t  rsp_o,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i
);

  acc_unit_pkg::unit_state_e state_q;
  acc_unit_pkg::mul_cnt_t    cnt_q;
  logic [`CC_ID_W-1:0]       id_q;
  logic [`CC_DATA_W-1:0]     mcand_q;
  logic [`CC_DATA_W-1:0]     mplier_q;
  logic [`CC_DATA_W-1:0]     result_q;
  logic                      accept;
  logic                      is_mul;
  logic                      mul_last;

  // Single-cycle ops
  function automatic logic [`CC_DATA_W-1:0] alu(
    input acc_unit_pkg::acc_op_e op,
    input logic [`CC_DATA_W-1:0] a,
    input logic [`CC_DATA_W-1:0] b
  );
    logic [`CC_DATA_W-1:0] res;
    case (op)
      acc_unit_pkg::ADD: res = a + b;
      acc_unit_pkg::SUB: res = a - b;
      acc_unit_pkg::AND: res = a & b;
      acc_unit_pkg::OR:  res = a | b;
      acc_unit_pkg::XOR: res = a ^ b;
      acc_unit_pkg::SLL: res = a << b[$clog2(`CC_DATA_W)-1:0];
      default:           res = '0;
    endcase
    return res;
  endfunction

  assign req_ready_o = (state_q == acc_unit_pkg::IDLE);
  assign accept      = req_valid_i & req_ready_o;
  assign is_mul      = (req_i.op == acc_unit_pkg::MUL);
  assign mul_last    = (cnt_q == acc_unit_pkg::mul_cnt_t'(`CC_MUL_CYCLES - 1));

  assign rsp_valid_o = (state_q == acc_unit_pkg::DONE);
  assign rsp_o       = '{
    id:    id_q,
    data:  result_q,
    error: 1'b0
  };

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= acc_unit_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        acc_unit_pkg::IDLE: begin
          if (accept) begin
            cnt_q   <= '0;
            state_q <= is_mul ? acc_unit_pkg::BUSY : acc_unit_pkg::DONE;
          end
        end
        acc_unit_pkg::BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (mul_last) begin
            state_q <= acc_unit_pkg::DONE;
          end
        end
        acc_unit_pkg::DONE: begin
          // Wait here for the arbiter
          if (rsp_ready_i) begin
            state_q <= acc_unit_pkg::IDLE;
          end
        end
        default: state_q <= acc_unit_pkg::IDLE;
      endcase
    end
  end

  // --------------------
  // Datapath
  // --------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q     <= req_i.id;
      mcand_q  <= req_i.arga;
      mplier_q <= req_i.argb;
      // Multiply accumulates into the result from zero
      result_q <= is_mul ? '0 : alu(req_i.op, req_i.arga, req_i.argb);
    end else if (state_q == acc_unit_pkg::BUSY) begin
      if (mplier_q[0]) begin
        result_q <= result_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

endmodule

`default_nettype wire

/* src/resp_arbiter.sv */
// --------------------
// Round-robin merge of unit and error
// responses into one registered output
// --------------------

`default_nettype none

`include "cc_macros.svh"

module resp_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  offload_pkg::offload_rsp_t [`CC_NUM_UNITS-1:0] unit_rsp_i,
  input  logic [`CC_NUM_UNITS-1:0]                      unit_valid_i,
  output logic [`CC_NUM_UNITS-1:0]                      unit_ready_o,
  input  offload_pkg::offload_rsp_t                     err_rsp_i,
  input  logic                                          err_valid_i,
  output logic                                          err_ready_o,
  output offload_pkg::offload_rsp_t                     rsp_o,
  output logic                                          rsp_valid_o,
  input  logic                                          rsp_ready_i
);

  // Units plus the error path
  localparam int unsigned NUM_REQ = `CC_NUM_UNITS + 1;
  localparam int unsigned IDX_W   = $clog2(NUM_REQ);

  offload_pkg::offload_rsp_t [NUM_REQ-1:0] in_rsp;
  logic [NUM_REQ-1:0]                      in_valid;
  logic [NUM_REQ-1:0]                      grant;
  logic [IDX_W-1:0]                        ptr_q;
  logic [IDX_W-1:0]                        win;
  logic                                    found;
  logic                                    load_en;
  offload_pkg::offload_rsp_t               rsp_q;
  logic                                    valid_q;

  // Error path sits on the top index
  assign in_rsp   = {err_rsp_i, unit_rsp_i};
  assign in_valid = {err_valid_i, unit_valid_i};

  // Output register free or draining
  assign load_en = ~valid_q | rsp_ready_i;

  // --------------------
  // Priority search
  // --------------------
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    win   = '0;
    for (int unsigned i = 0; i < NUM_REQ; i++) begin
      idx = (int'(ptr_q) + i) % NUM_REQ;
      if (!found && in_valid[idx]) begin
        found = 1'b1;
        win   = IDX_W'(idx);
      end
    end
  end

  assign grant        = (load_en & found) ? (NUM_REQ'(1) << win) : '0;
  assign unit_ready_o = grant[`CC_NUM_UNITS-1:0];
  assign err_ready_o  = grant[`CC_NUM_UNITS];

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      ptr_q   <= '0;
    end else if (load_en) begin
      valid_q <= found;
      if (found) begin
        // Winner drops to lowest priority
        ptr_q <= (win == IDX_W'(NUM_REQ - 1)) ? '0 : win + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en && found) begin
      rsp_q <= in_rsp[win];
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = valid_q;

endmodule

`default_nettype wire

/* src/offload_cluster.sv */
// --------------------
// Offload cluster top: dispatcher,
// accelerator unit array, response arbiter
// --------------------

`default_nettype none

`include "cc_macros.svh"

module offload_cluster (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  offload_pkg::offload_req_t  req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output offload_pkg::offload_rsp_t  rsp_o,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i
);

  offload_pkg::offload_req_t                     unit_req;
  logic [`CC_NUM_UNITS-1:0]                      unit_valid;
  logic [`CC_NUM_UNITS-1:0]                      unit_ready;
  offload_pkg::offload_rsp_t [`CC_NUM_UNITS-1:0] unit_rsp;
  logic [`CC_NUM_UNITS-1:0]                      unit_rsp_valid;
  logic [`CC_NUM_UNITS-1:0]                      unit_rsp_ready;
  offload_pkg::offload_rsp_t                     err_rsp;
  logic                                          err_valid;
  logic                                          err_ready;

  offload_dispatch u_dispatch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .unit_req_o   (unit_req),
    .unit_valid_o (unit_valid),
    .unit_ready_i (unit_ready),
    .err_rsp_o    (err_rsp),
    .err_valid_o  (err_valid),
    .err_ready_i  (err_ready)
  );

  // One unit per select value
  for (genvar i = 0; i < `CC_NUM_UNITS; i++) begin : gen_units
    acc_unit u_unit (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (unit_req),
      .req_valid_i (unit_valid[i]),
      .req_ready_o (unit_ready[i]),
      .rsp_o       (unit_rsp[i]),
      .rsp_valid_o (unit_rsp_valid[i]),
      .rsp_ready_i (unit_rsp_ready[i])
    );
  end

  resp_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .unit_rsp_i   (unit_rsp),
    .unit_valid_i (unit_rsp_valid),
    .unit_ready_o (unit_rsp_ready),
    .err_rsp_i    (err_rsp),
    .err_valid_i  (err_valid),
    .err_ready_o  (err_ready),
    .rsp_o        (rsp_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i)
  );

endmodule

`default_nettype wire

/* dv/offload_cluster_assertions.sv */
// --------------------
// Handshake assertions on the offload
// cluster ports, bound to the top level
// --------------------

`default_nettype none

`include "cc_macros.svh"

module offload_cluster_assertions (
  input logic                      clk_i,
  input logic                      rst_ni,
  input offload_pkg::offload_req_t req_i,
  input logic                      req_valid_i,
  input logic                      req_ready_i,
  input offload_pkg::offload_rsp_t rsp_i,
  input logic                      rsp_valid_i,
  input logic                      rsp_ready_i
);

  // One pending bit per tag
  logic [(1 << `CC_ID_W)-1:0] pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      if (req_valid_i && req_ready_i) begin
        pending_q[req_i.id] <= 1'b1;
      end
      if (rsp_valid_i && rsp_ready_i) begin
        pending_q[rsp_i.id] <= 1'b0;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk_i) !rst_ni |-> !rsp_valid_i)
    else $error("response valid during reset");

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("response changed while stalled");

  a_rsp_known_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && rsp_ready_i |-> pending_q[rsp_i.id])
    else $error("response tag not outstanding");

endmodule

bind offload_cluster offload_cluster_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .rsp_i       (rsp_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i)
);

`default_nettype wire

/* dv/offload_cluster_tb.sv */
// --------------------
// Offload cluster testbench: directed tests,
// scoreboard per tag, watchdog
// --------------------

`default_nettype none

`include "cc_macros.svh"

module offload_cluster_tb;

  localparam int NUM_IDS   = 1 << `CC_ID_W;
  localparam int NUM_REQS  = 89;
  localparam int WD_CYCLES = NUM_REQS * (`CC_MUL_CYCLES + 10) * 2;

  logic                      clk_i;
  logic                      rst_ni;
  offload_pkg::offload_req_t req_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  offload_pkg::offload_rsp_t rsp_o;
  logic                      rsp_valid_o;
  logic                      rsp_ready_i;

  // Expected entries per tag
  logic [`CC_DATA_W-1:0] exp_data [NUM_IDS];
  logic                  exp_err [NUM_IDS];
  int                    exp_unit [NUM_IDS];
  int                    issue_seq [NUM_IDS];
  int                    ret_order [NUM_IDS];
  logic [NUM_IDS-1:0]    pending;
  // Counts per unit, the error path on the top index
  int                    issued_cnt [`CC_NUM_UNITS+1];
  int                    returned_cnt [`CC_NUM_UNITS+1];
  int                    outstanding;
  int                    ret_total;
  int                    mon_unit;
  logic [`CC_ID_W-1:0]   mon_id;
  logic [`CC_ID_W-1:0]   next_id;
  logic [`CC_ID_W-1:0]   last_id;
  logic                  rand_ready;
  string                 test_name;

  offload_cluster dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  always #4 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
    end
  endtask

  // Expected result from the opcode rules
  function automatic logic [`CC_DATA_W-1:0] ref_result(input acc_unit_pkg::acc_op_e op,
      input logic [`CC_DATA_W-1:0] a, input logic [`CC_DATA_W-1:0] b);
    logic [2*`CC_DATA_W-1:0] prod;
    prod = (2*`CC_DATA_W)'(a) * (2*`CC_DATA_W)'(b);
    case (op)
      acc_unit_pkg::ADD: return a + b;
      acc_unit_pkg::SUB: return a - b;
      acc_unit_pkg::AND: return a & b;
      acc_unit_pkg::OR:  return a | b;
      acc_unit_pkg::XOR: return a ^ b;
      acc_unit_pkg::SLL: return a << b[4:0];
      acc_unit_pkg::MUL: return prod[`CC_DATA_W-1:0];
      default:           return '0;
    endcase
  endfunction

  // Issue one request, waiting for a free tag and for the handshake
  task automatic send_req(input logic [`CC_SEL_W-1:0] sel, input acc_unit_pkg::acc_op_e op,
                          input logic [`CC_DATA_W-1:0] a, input logic [`CC_DATA_W-1:0] b);
    logic [`CC_ID_W-1:0] tag;
    logic                taken;
    tag     = next_id;
    next_id = next_id + 1'b1;
    while (pending[tag]) begin
      @(posedge clk_i);
      #1;
    end
    exp_err[tag]   = (int'(sel) >= `CC_NUM_UNITS);
    exp_data[tag]  = exp_err[tag] ? '0 : ref_result(op, a, b);
    exp_unit[tag]  = int'(sel);
    issue_seq[tag] = issued_cnt[sel];
    issued_cnt[sel]++;
    pending[tag] = 1'b1;
    outstanding++;
    last_id     = tag;
    req_i       = '{id: tag, sel: sel, op: op, arga: a, argb: b};
    req_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
      #1;
    end while (!taken);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (outstanding != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // --------------------
  // Response monitor
  // --------------------
  always @(negedge clk_i) begin
    if (rst_ni && rsp_valid_o && rsp_ready_i) begin
      mon_id = rsp_o.id;
      if (!pending[mon_id]) begin
        abort_run($sformatf("response with tag %0d that was not outstanding", mon_id));
      end
      mon_unit = exp_unit[mon_id];
      check_eq({test_name, " data"}, exp_data[mon_id], rsp_o.data);
      check_eq({test_name, " error"}, exp_err[mon_id], rsp_o.error);
      check_eq({test_name, " order"}, issue_seq[mon_id], returned_cnt[mon_unit]);
      returned_cnt[mon_unit]++;
      ret_order[mon_id] = ret_total;
      ret_total++;
      pending[mon_id] = 1'b0;
      outstanding--;
    end
  end

  // Random response back-pressure
  always @(posedge clk_i) begin
    #1;
    if (rand_ready) begin
      rsp_ready_i = 1'($urandom_range(0, 1));
    end
  end

  // --------------------
  // Tests
  // --------------------
  task automatic test_ops();
    test_name = "test_ops";
    for (int u = 0; u < `CC_NUM_UNITS; u++) begin
      for (int o = 0; o <= 6; o++) begin
        send_req(2'(u), acc_unit_pkg::acc_op_e'(3'(o)), $urandom(), $urandom());
        wait_idle();
      end
    end
  endtask

  task automatic test_bad_sel();
    test_name = "test_bad_sel";
    send_req(2'd3, acc_unit_pkg::ADD, $urandom(), $urandom());
    wait_idle();
    // A stray unit result would arrive here with a retired tag
    repeat (4) @(posedge clk_i);
    #1;
  endtask

  task automatic test_overlap();
    logic [`CC_ID_W-1:0] mul_id;
    logic [`CC_ID_W-1:0] add_id;
    test_name = "test_overlap";
    send_req(2'd0, acc_unit_pkg::MUL, $urandom(), $urandom());
    mul_id = last_id;
    send_req(2'd1, acc_unit_pkg::ADD, $urandom(), $urandom());
    add_id = last_id;
    wait_idle();
    check_eq("test_overlap order", 1, ret_order[add_id] < ret_order[mul_id]);
  endtask

  task automatic test_backpressure();
    offload_pkg::offload_rsp_t held;
    test_name   = "test_backpressure";
    rsp_ready_i = 1'b0;
    send_req(2'd0, acc_unit_pkg::ADD, $urandom(), $urandom());
    send_req(2'd1, acc_unit_pkg::XOR, $urandom(), $urandom());
    send_req(2'd2, acc_unit_pkg::SUB, $urandom(), $urandom());
    send_req(2'd0, acc_unit_pkg::OR, $urandom(), $urandom());
    // Unit 0 is full, so this one stays in the dispatcher
    send_req(2'd0, acc_unit_pkg::AND, $urandom(), $urandom());
    @(negedge clk_i);
    held = rsp_o;
    repeat (20) begin
      check_eq("test_backpressure valid", 1, rsp_valid_o);
      check_eq("test_backpressure rsp", 64'(held), 64'(rsp_o));
      check_eq("test_backpressure stall", 0, req_ready_o);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    rsp_ready_i = 1'b1;
    wait_idle();
  endtask

  task automatic test_stream();
    test_name  = "test_stream";
    rand_ready = 1'b1;
    for (int n = 0; n < 60; n++) begin
      send_req(2'($urandom_range(0, 3)), acc_unit_pkg::acc_op_e'(3'($urandom_range(0, 6))),
               $urandom(), $urandom());
    end
    rand_ready  = 1'b0;
    rsp_ready_i = 1'b1;
    wait_idle();
  endtask

  initial begin
    repeat (WD_CYCLES) @(posedge clk_i);
    abort_run("timeout: no response");
  end

  initial begin
    void'($urandom(66));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    rand_ready  = 1'b0;
    next_id     = '0;
    pending     = '0;
    outstanding = 0;
    ret_total   = 0;
    test_name   = "reset";
    for (int i = 0; i <= `CC_NUM_UNITS; i++) begin
      issued_cnt[i]   = 0;
      returned_cnt[i] = 0;
    end
    @(negedge clk_i);
    check_eq("reset rsp_valid", 0, rsp_valid_o);
    check_eq("reset req_ready", 1, req_ready_o);
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_ops();
    test_bad_sel();
    test_overlap();
    test_backpressure();
    test_stream();
    repeat (4) @(posedge clk_i);
    if (outstanding != 0 || ret_total != NUM_REQS) begin
      abort_run("responses missing at end of run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/acc_unit_pkg.sv
src/offload_pkg.sv
src/offload_dispatch.sv
src/acc_unit.sv
src/resp_arbiter.sv
src/offload_cluster.sv
dv/offload_cluster_assertions.sv
dv/offload_cluster_tb.sv

/* Makefile */
# Verilator build and run of the offload cluster testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module offload_cluster_tb -Mdir obj_dir
	./obj_dir/Voffload_cluster_tb

clean:
	rm -rf obj_dir
